// File: build.f
src/lc3b_types.sv
src/cache_types.sv
src/array.sv
src/cache_datapath.sv
src/cache_control.sv
src/line_adapter.sv
src/cache.sv
verif/cache_chk.sv
verif/cache_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wall
TOP      = cache_tb
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
	  (echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: verif/cache_tb.sv
`timescale 1ns/10ps

module cache_tb;
  import lc3b_types::*;

  localparam int num_requests  = 400;
  localparam int num_directed  = 5;
  localparam int timeout_cycles = (num_requests + num_directed) * 20 + 100 + 8;

  logic          clk;
  logic          reset;
  logic          mem_read;
  logic          mem_write;
  lc3b_addr      mem_address;
  lc3b_word      mem_wdata;
  lc3b_mem_wmask mem_byte_enable;
  logic          mem_resp;
  lc3b_word      mem_rdata;
  logic          pmem_read;
  logic          pmem_write;
  lc3b_addr      pmem_address;
  lc3b_c_line    pmem_wdata;
  logic          pmem_resp;
  lc3b_c_line    pmem_rdata;

  integer seed = 32'hc9b300c8;
  int     errors = 0;
  int     cycle_count = 0;

  lc3b_c_line pmem [4096];  // physical memory, one entry per line
  logic [7:0] ref_mem [65536];  // reference, flat bytes

  // tag, dirty and LRU model of the cache
  logic [8:0] m_tag [8][2];
  logic       m_valid [8][2];
  logic       m_dirty [8][2];
  logic       m_lru [8];

  logic     exp_wb;
  lc3b_addr exp_wb_addr;
  int       wb_count;
  int       fill_count;
  lc3b_addr last_fill_addr;
  bit       busy;
  int       wait_left;

  cache dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  initial begin
    while (cycle_count <= timeout_cycles) @(posedge clk);
    $display("timeout: the DUT stopped answering after %0d cycles", cycle_count);
    $display("Finished with errors");
    $finish;
  end

  task automatic check_word(input string name, input lc3b_word got, input lc3b_word exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_line(input string name, input lc3b_c_line got, input lc3b_c_line exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input lc3b_addr got, input lc3b_addr exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic lc3b_c_line ref_line(input lc3b_addr a);
    lc3b_c_line l;
    for (int b = 0; b < 16; b++) begin
      l[b*8 +: 8] = ref_mem[{a[15:4], 4'(b)}];
    end
    return l;
  endfunction

  // physical memory, answers after 1 to 6 cycles
  always @(posedge clk) begin
    if (reset) begin
      pmem_resp <= 1'b0;
      busy = 1'b0;
    end else if (pmem_resp) begin
      pmem_resp <= 1'b0;
    end else if (pmem_read || pmem_write) begin
      if (!busy) begin
        busy = 1'b1;
        wait_left = ($unsigned($random(seed)) % 6) + 1;
      end
      wait_left = wait_left - 1;
      if (wait_left == 0) begin
        if (pmem_write) begin
          if (!exp_wb) begin
            $display("unexpected writeback of a clean or invalid line at %h", pmem_address);
            errors++;
          end else begin
            check_addr("pmem_address", pmem_address, exp_wb_addr);
          end
          check_line("pmem_wdata", pmem_wdata, ref_line(pmem_address));
          pmem[pmem_address[15:4]] = pmem_wdata;
          wb_count++;
        end else begin
          pmem_rdata <= pmem[pmem_address[15:4]];
          last_fill_addr = pmem_address;
          fill_count++;
        end
        pmem_resp <= 1'b1;
        busy = 1'b0;
      end
    end
  end

  task automatic do_request(input logic wr, input lc3b_addr a, input lc3b_word d,
                            input lc3b_mem_wmask m);
    logic [2:0] s;
    logic [8:0] t;
    logic       miss;
    logic       way;
    lc3b_word   exp_word;
    s = a[6:4];
    t = a[15:7];
    miss = 1'b0;
    if (m_valid[s][0] && m_tag[s][0] == t) begin
      way = 1'b0;
    end else if (m_valid[s][1] && m_tag[s][1] == t) begin
      way = 1'b1;
    end else begin
      miss = 1'b1;
      way = m_lru[s];
    end
    exp_wb = miss && m_valid[s][way] && m_dirty[s][way];
    exp_wb_addr = {m_tag[s][way], s, 4'b0000};
    wb_count = 0;
    fill_count = 0;

    @(posedge clk);
    mem_read        <= ~wr;
    mem_write       <= wr;
    mem_address     <= a;
    mem_wdata       <= d;
    mem_byte_enable <= m;
    do @(posedge clk); while (!mem_resp);
    mem_read  <= 1'b0;
    mem_write <= 1'b0;

    if (wr) begin
      if (m[0]) ref_mem[{a[15:1], 1'b0}] = d[7:0];
      if (m[1]) ref_mem[{a[15:1], 1'b1}] = d[15:8];
    end else begin
      exp_word = {ref_mem[{a[15:1], 1'b1}], ref_mem[{a[15:1], 1'b0}]};
      check_word("mem_rdata", mem_rdata, exp_word);
    end
    if (wb_count != int'(exp_wb)) begin
      $display("writeback count %0d at %h does not match the model", wb_count, a);
      errors++;
    end
    if (fill_count != int'(miss)) begin
      $display("fill count %0d at %h does not match the model", fill_count, a);
      errors++;
    end

    if (miss) begin
      m_tag[s][way]   = t;
      m_valid[s][way] = 1'b1;
      m_dirty[s][way] = 1'b0;
    end
    if (wr) m_dirty[s][way] = 1'b1;
    m_lru[s] = (way == 1'b0);
  endtask

  initial begin
    lc3b_addr a;
    reset = 1'b1;
    mem_read = 1'b0;
    mem_write = 1'b0;
    mem_address = '0;
    mem_wdata = '0;
    mem_byte_enable = '0;
    pmem_resp = 1'b0;
    pmem_rdata = '0;
    for (int i = 0; i < 4096; i++) begin
      for (int w = 0; w < 4; w++) begin
        pmem[i][w*32 +: 32] = $random(seed);
      end
      for (int b = 0; b < 16; b++) begin
        ref_mem[{12'(i), 4'(b)}] = pmem[i][b*8 +: 8];
      end
    end
    for (int s = 0; s < 8; s++) begin
      m_valid[s][0] = 1'b0;
      m_valid[s][1] = 1'b0;
      m_dirty[s][0] = 1'b0;
      m_dirty[s][1] = 1'b0;
      m_tag[s][0] = '0;
      m_tag[s][1] = '0;
      m_lru[s] = 1'b0;
    end
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    for (int n = 0; n < num_requests; n++) begin
      a = {7'd0, 2'($random(seed)), 3'($random(seed)), 3'($random(seed)), 1'b0};  // 4 tags
      do_request(1'($random(seed)), a, 16'($random(seed)), 2'($random(seed)));
    end

    // A, B, A, then C evicts B, so B must be fetched again
    do_request(1'b0, 16'h0050, '0, 2'b11);
    do_request(1'b0, 16'h00d0, '0, 2'b11);
    do_request(1'b0, 16'h0050, '0, 2'b11);
    do_request(1'b0, 16'h0150, '0, 2'b11);
    do_request(1'b0, 16'h00d0, '0, 2'b11);
    check_addr("pmem_address", last_fill_addr, 16'h00d0);

    repeat (2) @(posedge clk);
    errors += dut.control.chk.fail_count;  // bound assertions count too
    $display("errors: %0d after %0d requests", errors, num_requests + num_directed);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : cache_tb

// File: verif/cache_chk.sv
`timescale 1ns/10ps

module cache_chk (
  input logic                   clk,
  input logic                   reset,
  input logic                   mem_resp,
  input logic                   pmem_read,
  input logic                   pmem_write,
  input logic                   pmem_resp,
  input cache_types::cache_state state
);
  import cache_types::*;

  int fail_count = 0;  // failed assertions so far

  a_one_strobe: assert property (@(posedge clk) disable iff (reset)
    !(pmem_read && pmem_write)) else begin
    $error("pmem_read and pmem_write both high");
    fail_count++;
  end

  a_resp_pulse: assert property (@(posedge clk) disable iff (reset)
    mem_resp |=> !mem_resp) else begin
    $error("mem_resp held longer than one cycle");
    fail_count++;
  end

  a_read_held: assert property (@(posedge clk) disable iff (reset)
    (pmem_read && !pmem_resp) |=> pmem_read) else begin
    $error("pmem_read dropped early");
    fail_count++;
  end

  a_write_held: assert property (@(posedge clk) disable iff (reset)
    (pmem_write && !pmem_resp) |=> pmem_write) else begin
    $error("pmem_write dropped early");
    fail_count++;
  end

  // a finished fill makes the held request hit in the next cycle
  a_fill_hits: assert property (@(posedge clk) disable iff (reset)
    (state == s_fill && pmem_resp) |=> mem_resp) else begin
    $error("no hit in the cycle after a completed fill");
    fail_count++;
  end

endmodule : cache_chk

bind cache_control cache_chk chk (.*);

// File: src/cache.sv
`timescale 1ns/10ps

module cache (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      mem_read,
  input  logic                      mem_write,
  input  lc3b_types::lc3b_addr      mem_address,
  input  lc3b_types::lc3b_word      mem_wdata,
  input  lc3b_types::lc3b_mem_wmask mem_byte_enable,
  output logic                      mem_resp,
  output lc3b_types::lc3b_word      mem_rdata,
  output logic                      pmem_read,
  output logic                      pmem_write,
  output lc3b_types::lc3b_addr      pmem_address,
  output lc3b_types::lc3b_c_line    pmem_wdata,
  input  logic                      pmem_resp,
  input  lc3b_types::lc3b_c_line    pmem_rdata
);
  import lc3b_types::*;

  logic write_enable;
  logic control_load;
  logic lru_load;
  logic hit;
  logic dirty;
  logic dead_man_walkin;

  lc3b_line_addr adr_out;
  lc3b_c_line    line_in;
  lc3b_c_line    data_out;

  // pmem_write is only up in s_writeback, so it picks the victim address
  assign pmem_address = pmem_write ? {adr_out, 4'b0000} : {mem_address[15:4], 4'b0000};
  assign pmem_wdata   = data_out;

  cache_control control (
    .clk             (clk),
    .reset           (reset),
    .mem_read        (mem_read),
    .mem_write       (mem_write),
    .pmem_resp       (pmem_resp),
    .hit             (hit),
    .dirty           (dirty),
    .dead_man_walkin (dead_man_walkin),
    .mem_resp        (mem_resp),
    .pmem_read       (pmem_read),
    .pmem_write      (pmem_write),
    .write_enable    (write_enable),
    .control_load    (control_load),
    .lru_load        (lru_load)
  );

  cache_datapath datapath (
    .clk             (clk),
    .reset           (reset),
    .address         (mem_address[15:4]),
    .data_in         (line_in),
    .write_enable    (write_enable),
    .control_load    (control_load),
    .lru_load        (lru_load),
    .hit             (hit),
    .dead_man_walkin (dead_man_walkin),
    .adr_out         (adr_out),
    .data_out        (data_out),
    .dirty           (dirty)
  );

  line_adapter adapter (
    .mem_address     (mem_address),
    .mem_wdata       (mem_wdata),
    .mem_byte_enable (mem_byte_enable),
    .line_in         (data_out),
    .pmem_rdata      (pmem_rdata),
    .control_load    (control_load),
    .mem_rdata       (mem_rdata),
    .line_out        (line_in)
  );

endmodule : cache

// File: src/line_adapter.sv
`timescale 1ns/10ps

module line_adapter (
  input  lc3b_types::lc3b_addr      mem_address,
  input  lc3b_types::lc3b_word      mem_wdata,
  input  lc3b_types::lc3b_mem_wmask mem_byte_enable,
  input  lc3b_types::lc3b_c_line    line_in,
  input  lc3b_types::lc3b_c_line    pmem_rdata,
  input  logic                      control_load,
  output lc3b_types::lc3b_word      mem_rdata,
  output lc3b_types::lc3b_c_line    line_out
);
  import lc3b_types::*;

  lc3b_c_offset offset;
  lc3b_c_line   merged;

  assign offset = mem_address[3:1];

  assign mem_rdata = line_in[offset * 16 +: 16];

  // replace only the enabled bytes of the addressed word
  always_comb begin
    merged = line_in;
    if (mem_byte_enable[0]) begin
      merged[offset * 16 +: 8] = mem_wdata[7:0];
    end
    if (mem_byte_enable[1]) begin
      merged[offset * 16 + 8 +: 8] = mem_wdata[15:8];
    end
  end

  assign line_out = control_load ? pmem_rdata : merged;  // fill takes the pmem line

endmodule : line_adapter

// File: src/cache_control.sv
`timescale 1ns/10ps

module cache_control (
  input  logic clk,
  input  logic reset,
  input  logic mem_read,
  input  logic mem_write,
  input  logic pmem_resp,
  input  logic hit,
  input  logic dirty,
  input  logic dead_man_walkin,
  output logic mem_resp,
  output logic pmem_read,
  output logic pmem_write,
  output logic write_enable,
  output logic control_load,
  output logic lru_load
);
  import cache_types::*;

  cache_state state;
  cache_state next_state;

  logic request;

  assign request = mem_read | mem_write;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      state <= next_state;
    end
  end

  // outputs
  always_comb begin
    mem_resp     = 1'b0;
    pmem_read    = 1'b0;
    pmem_write   = 1'b0;
    write_enable = 1'b0;
    control_load = 1'b0;
    lru_load     = 1'b0;

    case (state)
      s_idle: begin
        if (request && hit) begin
          mem_resp     = 1'b1;
          lru_load     = 1'b1;
          write_enable = mem_write;  // merge cpu word into hit line
        end
      end

      s_writeback: begin
        pmem_write = 1'b1;
      end

      s_fill: begin
        pmem_read    = 1'b1;
        control_load = pmem_resp;  // line lands at this edge
      end

      default: begin
      end
    endcase
  end

  // next state
  always_comb begin
    next_state = state;

    case (state)
      s_idle: begin
        if (request && !hit) begin
          if (dead_man_walkin && dirty) begin
            next_state = s_writeback;
          end else begin
            next_state = s_fill;
          end
        end
      end

      s_writeback: begin
        if (pmem_resp) begin
          next_state = s_fill;
        end
      end

      s_fill: begin
        if (pmem_resp) begin
          next_state = s_idle;  // request hits next cycle
        end
      end

      default: begin
        next_state = s_idle;
      end
    endcase
  end

endmodule : cache_control

// File: src/cache_datapath.sv
`timescale 1ns/10ps

module cache_datapath (
  input  logic                      clk,
  input  logic                      reset,
  input  lc3b_types::lc3b_line_addr address,
  input  lc3b_types::lc3b_c_line    data_in,
  input  logic                      write_enable,
  input  logic                      control_load,
  input  logic                      lru_load,
  output logic                      hit,
  output logic                      dead_man_walkin,
  output lc3b_types::lc3b_line_addr adr_out,
  output lc3b_types::lc3b_c_line    data_out,
  output logic                      dirty
);
  import lc3b_types::*;
  import cache_types::*;

  logic [index_width-1:0] index;
  logic [tag_width-1:0]   tag;

  logic [tag_width:0] valid_tag_in;  // {valid, tag}
  logic [tag_width:0] valid_tag0_out;
  logic [tag_width:0] valid_tag1_out;

  lc3b_c_line data0_out;
  lc3b_c_line data1_out;

  logic dirty0_out;
  logic dirty1_out;
  logic dirty_in;

  logic lru_out;  // way to evict next
  logic lru_in;

  logic hit0;
  logic hit1;

  logic data0_write;
  logic data1_write;
  logic tag0_write;
  logic tag1_write;

  logic                 victim_valid;
  logic                 victim_dirty;
  logic [tag_width-1:0] victim_tag;
  lc3b_c_line           victim_line;

  assign index = address[index_width-1:0];
  assign tag   = address[index_width +: tag_width];

  assign valid_tag_in = {1'b1, tag};

  // tag compare on both ways
  assign hit0 = (valid_tag0_out == {1'b1, tag});
  assign hit1 = (valid_tag1_out == {1'b1, tag});
  assign hit  = hit0 | hit1;

  always_comb begin
    if (lru_out) begin
      victim_valid = valid_tag1_out[tag_width];
      victim_tag   = valid_tag1_out[tag_width-1:0];
      victim_dirty = dirty1_out;
      victim_line  = data1_out;
    end else begin
      victim_valid = valid_tag0_out[tag_width];
      victim_tag   = valid_tag0_out[tag_width-1:0];
      victim_dirty = dirty0_out;
      victim_line  = data0_out;
    end
  end

  assign dead_man_walkin = ~hit & victim_valid;
  assign dirty           = ~hit & victim_dirty;
  assign adr_out         = {victim_tag, index};

  always_comb begin
    if (hit0) begin
      data_out = data0_out;
    end else if (hit1) begin
      data_out = data1_out;
    end else begin
      data_out = victim_line;  // goes out on writeback
    end
  end

  // cpu write lands in the hit way, a fill in the victim way
  assign tag0_write  = control_load & ~lru_out;
  assign tag1_write  = control_load & lru_out;
  assign data0_write = (hit0 & write_enable) | tag0_write;
  assign data1_write = (hit1 & write_enable) | tag1_write;
  assign dirty_in    = ~control_load;  // fill leaves the line clean

  assign lru_in = hit0;  // point at the other way

  array #(.width($bits(lc3b_c_line))) data0 (
    .clk     (clk),
    .reset   (reset),
    .write   (data0_write),
    .index   (index),
    .datain  (data_in),
    .dataout (data0_out)
  );

  array #(.width($bits(lc3b_c_line))) data1 (
    .clk     (clk),
    .reset   (reset),
    .write   (data1_write),
    .index   (index),
    .datain  (data_in),
    .dataout (data1_out)
  );

  array #(.width(tag_width + 1)) valid_tag0 (
    .clk     (clk),
    .reset   (reset),
    .write   (tag0_write),
    .index   (index),
    .datain  (valid_tag_in),
    .dataout (valid_tag0_out)
  );

  array #(.width(tag_width + 1)) valid_tag1 (
    .clk     (clk),
    .reset   (reset),
    .write   (tag1_write),
    .index   (index),
    .datain  (valid_tag_in),
    .dataout (valid_tag1_out)
  );

  array #(.width(1)) dirty0 (
    .clk     (clk),
    .reset   (reset),
    .write   (data0_write),
    .index   (index),
    .datain  (dirty_in),
    .dataout (dirty0_out)
  );

  array #(.width(1)) dirty1 (
    .clk     (clk),
    .reset   (reset),
    .write   (data1_write),
    .index   (index),
    .datain  (dirty_in),
    .dataout (dirty1_out)
  );

  array #(.width(1)) lru (
    .clk     (clk),
    .reset   (reset),
    .write   (lru_load),
    .index   (index),
    .datain  (lru_in),
    .dataout (lru_out)
  );

endmodule : cache_datapath

// File: src/array.sv
`timescale 1ns/10ps

module array #(
  parameter int width = 128
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               write,
  input  logic [cache_types::index_width-1:0] index,
  input  logic [width-1:0]                   datain,
  output logic [width-1:0]                   dataout
);
  import cache_types::*;

  logic [width-1:0] data [set_count];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < set_count; i++) begin
        data[i] <= '0;
      end
    end else if (write) begin
      data[index] <= datain;
    end
  end

  assign dataout = data[index];  // async read

endmodule : array

// File: src/cache_types.sv
package cache_types;

  localparam int index_width = 3;
  localparam int tag_width   = 9;
  localparam int set_count   = 1 << index_width;

  // miss handling
  typedef enum logic [1:0] {
    s_idle,
    s_writeback,  // victim line out to pmem
    s_fill        // new line in from pmem
  } cache_state;

endpackage : cache_types

// File: src/lc3b_types.sv
package lc3b_types;

  // cpu side
  typedef logic [15:0] lc3b_word;
  typedef logic [15:0] lc3b_addr;
  typedef logic [1:0]  lc3b_mem_wmask;  // bit 1 is the high byte

  // cache line of eight words, word 0 in the low bits
  typedef logic [127:0] lc3b_c_line;

  // word offset within a line, address bits [3:1]
  typedef logic [2:0] lc3b_c_offset;

  // address bits [15:4], tag above index
  typedef logic [11:0] lc3b_line_addr;

endpackage : lc3b_types
